// ==== verilog/cpu_pkg.sv ====
package cpu_pkg;

	// Datapath widths
	localparam int DATA_W    = 16;
	localparam int REG_SEL_W = 4;

	// Bit positions in the flag word
	localparam int FLAG_Z = 0;
	localparam int FLAG_V = 1;
	localparam int FLAG_N = 2;

	// --------------------------------------------------
	// Opcodes
	// --------------------------------------------------
	localparam logic [3:0] OP_ADD = 4'h0;
	localparam logic [3:0] OP_SUB = 4'h1;
	localparam logic [3:0] OP_XOR = 4'h2;
	localparam logic [3:0] OP_AND = 4'h3;
	localparam logic [3:0] OP_SLL = 4'h4;
	localparam logic [3:0] OP_SRA = 4'h5;
	localparam logic [3:0] OP_ROR = 4'h6;
	localparam logic [3:0] OP_OR  = 4'h7;
	localparam logic [3:0] OP_LW  = 4'h8;
	localparam logic [3:0] OP_SW  = 4'h9;
	localparam logic [3:0] OP_LHB = 4'hA;
	localparam logic [3:0] OP_LLB = 4'hB;
	localparam logic [3:0] OP_B   = 4'hC;
	localparam logic [3:0] OP_BR  = 4'hD;
	localparam logic [3:0] OP_PCS = 4'hE;
	localparam logic [3:0] OP_HLT = 4'hF;

	// Branch conditions
	localparam logic [2:0] CC_NE = 3'd0;
	localparam logic [2:0] CC_EQ = 3'd1;
	localparam logic [2:0] CC_GT = 3'd2;
	localparam logic [2:0] CC_LT = 3'd3;
	localparam logic [2:0] CC_GE = 3'd4;
	localparam logic [2:0] CC_LE = 3'd5;
	localparam logic [2:0] CC_OV = 3'd6;
	localparam logic [2:0] CC_UN = 3'd7;

	// Memory sizes in words
	localparam int IMEM_DEPTH = 256;
	localparam int DMEM_DEPTH = 256;

	// Operand forward selects
	localparam logic [1:0] FWD_NONE = 2'd0;
	localparam logic [1:0] FWD_WB   = 2'd1;
	localparam logic [1:0] FWD_MEM  = 2'd2;

	// One instruction word, three field layouts
	typedef union packed {
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [3:0] rs;
			logic [3:0] rt;
		} r;
		struct packed {
			logic [3:0] opcode;
			logic [3:0] rd;
			logic [7:0] imm8;
		} i;
		struct packed {
			logic [3:0] opcode;
			logic [2:0] cc;
			logic [8:0] imm9;
		} b;
	} instr_t;

endpackage

// ==== verilog/memory1c.sv ====
`timescale 1ns/1ps

module memory1c #(
	parameter int DEPTH = 256
) (
	input  logic        clk,
	input  logic        rst,
	input  logic        enable,
	input  logic        wr,
	input  logic [7:0]  addr,
	input  logic [15:0] data_in,
	output logic [15:0] data_out
);

	// Contents survive reset so a loaded program stays put
	logic [15:0] mem [DEPTH];

	assign data_out = enable ? mem[addr] : '0;

	always_ff @(posedge clk) begin
		if (enable && wr)
			mem[addr] <= data_in;
	end

	// Address must be known once the pipeline runs
	assert property (@(posedge clk) disable iff (rst) enable |-> !$isunknown(addr));

endmodule

// ==== verilog/register_file.sv ====
`timescale 1ns/1ps

module register_file (
	input  logic        clk,
	input  logic        rst,
	input  logic [3:0]  rd_sel_1,
	input  logic [3:0]  rd_sel_2,
	input  logic        wr_en,
	input  logic [3:0]  wr_sel,
	input  logic [15:0] wr_data,
	output logic [15:0] rd_data_1,
	output logic [15:0] rd_data_2
);

	logic [15:0] regs [16];

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				regs[i] <= '0;
		end else if (wr_en && wr_sel != 4'd0) begin
			regs[wr_sel] <= wr_data;
		end
	end

	// r0 is hardwired, a same-cycle write is passed straight through
	always_comb begin
		if (rd_sel_1 == 4'd0)
			rd_data_1 = '0;
		else if (wr_en && wr_sel == rd_sel_1)
			rd_data_1 = wr_data;
		else
			rd_data_1 = regs[rd_sel_1];

		if (rd_sel_2 == 4'd0)
			rd_data_2 = '0;
		else if (wr_en && wr_sel == rd_sel_2)
			rd_data_2 = wr_data;
		else
			rd_data_2 = regs[rd_sel_2];
	end

endmodule

// ==== verilog/alu.sv ====
`timescale 1ns/1ps

module alu
	import cpu_pkg::*;
(
	input  logic [DATA_W-1:0] in_a,
	input  logic [DATA_W-1:0] in_b,
	input  logic [2:0]        op,
	output logic [DATA_W-1:0] result,
	output logic [2:0]        flags,
	output logic [2:0]        flag_wen
);

	logic [DATA_W-1:0]   sum, diff, sat;
	logic [2*DATA_W-1:0] rot_wide;
	logic                add_ovf, sub_ovf, ovf;

	assign sum = in_a + in_b;
	assign diff = in_a - in_b;
	assign add_ovf = (in_a[DATA_W-1] == in_b[DATA_W-1]) && (sum[DATA_W-1] != in_a[DATA_W-1]);
	assign sub_ovf = (in_a[DATA_W-1] != in_b[DATA_W-1]) && (diff[DATA_W-1] != in_a[DATA_W-1]);
	// Clamp toward the sign of the first operand
	assign sat = in_a[DATA_W-1] ? 16'h8000 : 16'h7FFF;
	assign rot_wide = {in_a, in_a} >> in_b[3:0];

	always_comb begin
		ovf = 1'b0;
		flag_wen = '0;
		flag_wen[FLAG_Z] = 1'b1;
		case ({1'b0, op})
			OP_ADD: begin
				result = add_ovf ? sat : sum;
				ovf = add_ovf;
				flag_wen = '1;
			end
			OP_SUB: begin
				result = sub_ovf ? sat : diff;
				ovf = sub_ovf;
				flag_wen = '1;
			end
			OP_XOR:  result = in_a ^ in_b;
			OP_AND:  result = in_a & in_b;
			OP_SLL:  result = in_a << in_b[3:0];
			OP_SRA:  result = $signed(in_a) >>> in_b[3:0];
			OP_ROR:  result = rot_wide[DATA_W-1:0];
			default: result = in_a | in_b;
		endcase
	end

	always_comb begin
		flags[FLAG_Z] = (result == '0);
		flags[FLAG_V] = ovf;
		flags[FLAG_N] = result[DATA_W-1];
	end

endmodule

// ==== verilog/branch_ctrl.sv ====
`timescale 1ns/1ps

module branch_ctrl
	import cpu_pkg::*;
(
	input  instr_t            instr,
	input  logic [DATA_W-1:0] pc_plus_2,
	input  logic [2:0]        flags,
	input  logic [DATA_W-1:0] reg_target,
	output logic              taken,
	output logic [DATA_W-1:0] target
);

	logic              z, v, n, cond;
	logic              is_b, is_br;
	logic [DATA_W-1:0] offset;

	assign z = flags[FLAG_Z];
	assign v = flags[FLAG_V];
	assign n = flags[FLAG_N];

	always_comb begin
		case (instr.b.cc)
			CC_NE:   cond = !z;
			CC_EQ:   cond = z;
			CC_GT:   cond = !z && !n;
			CC_LT:   cond = n;
			CC_GE:   cond = z || !n;
			CC_LE:   cond = n || z;
			CC_OV:   cond = v;
			CC_UN:   cond = 1'b1;
			default: cond = 1'b0;
		endcase
	end

	assign is_b = (instr.b.opcode == OP_B);
	assign is_br = (instr.b.opcode == OP_BR);
	assign taken = (is_b || is_br) && cond;

	// imm9 counts words from the next instruction
	assign offset = {{6{instr.b.imm9[8]}}, instr.b.imm9, 1'b0};
	assign target = is_br ? {reg_target[DATA_W-1:1], 1'b0} : pc_plus_2 + offset;

endmodule

// ==== verilog/hazard_unit.sv ====
`timescale 1ns/1ps

module hazard_unit
	import cpu_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  instr_t               id_instr,
	input  instr_t               ex_instr,
	input  logic                 ex_mem_read,
	input  logic                 mem_reg_write,
	input  logic [REG_SEL_W-1:0] mem_sel,
	input  logic                 wb_reg_write,
	input  logic [REG_SEL_W-1:0] wb_sel,
	input  logic [REG_SEL_W-1:0] ex_rs,
	input  logic [REG_SEL_W-1:0] ex_rt,
	input  logic                 wb_is_hlt,
	output logic                 stall,
	output logic [1:0]           fwd_a,
	output logic [1:0]           fwd_b,
	output logic                 hlt
);

	logic [3:0]           id_op;
	logic [REG_SEL_W-1:0] id_src_1, id_src_2, load_rd;
	logic                 uses_1, uses_2, hlt_q;

	// --------------------------------------------------
	// Load-use stall
	// --------------------------------------------------
	assign id_op = id_instr.r.opcode;
	assign id_src_1 = (id_op == OP_LHB || id_op == OP_LLB) ? id_instr.r.rd : id_instr.r.rs;
	assign id_src_2 = (id_op == OP_SW) ? id_instr.r.rd : id_instr.r.rt;
	// B, PCS and HLT touch no registers
	assign uses_1 = !(id_op inside {OP_B, OP_PCS, OP_HLT});
	assign uses_2 = id_op inside {OP_ADD, OP_SUB, OP_XOR, OP_AND, OP_OR, OP_SW};

	assign load_rd = ex_instr.r.rd;
	assign stall = ex_mem_read && (load_rd != '0)
		&& ((uses_1 && id_src_1 == load_rd) || (uses_2 && id_src_2 == load_rd));

	// --------------------------------------------------
	// Forwarding, youngest producer first
	// --------------------------------------------------
	function automatic logic [1:0] fwd_sel(input logic [REG_SEL_W-1:0] src);
		if (src == '0)
			return FWD_NONE;
		else if (mem_reg_write && mem_sel == src)
			return FWD_MEM;
		else if (wb_reg_write && wb_sel == src)
			return FWD_WB;
		else
			return FWD_NONE;
	endfunction

	always_comb begin
		fwd_a = fwd_sel(ex_rs);
		fwd_b = fwd_sel(ex_rt);
	end

	// Halt holds until the next reset
	always_ff @(posedge clk) begin
		if (rst)
			hlt_q <= 1'b0;
		else if (wb_is_hlt)
			hlt_q <= 1'b1;
	end

	assign hlt = hlt_q | wb_is_hlt;

	// The bubble behind a stall clears the load from execute
	assert property (@(posedge clk) disable iff (rst) stall |=> !stall);

endmodule

// ==== verilog/cpu.sv ====
`timescale 1ns/1ps

module cpu
	import cpu_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 imem_wr,
	input  logic [7:0]           imem_addr,
	input  logic [DATA_W-1:0]    imem_data,
	output logic                 hlt,
	output logic [DATA_W-1:0]    pc_out,
	output logic                 wb_valid,
	output logic [REG_SEL_W-1:0] wb_sel,
	output logic [DATA_W-1:0]    wb_data
);

	// Pipeline control
	logic       stall;
	logic       flush;
	logic [1:0] fwd_a, fwd_b;

	// Fetch
	logic [DATA_W-1:0] pc, pc_plus_2, imem_out;
	logic [7:0]        imem_rd_addr;
	logic              imem_load, halting_q, fetch_off;

	// Decode
	instr_t               id_instr;
	logic                 id_valid;
	logic [DATA_W-1:0]    id_pc2, id_data_1, id_data_2;
	logic [3:0]           id_op;
	logic                 id_lhb, id_llb, id_load, id_store, id_pcs, id_hlt, id_reg_write;
	logic [REG_SEL_W-1:0] id_sel_1, id_sel_2;

	// Execute
	instr_t               ex_instr;
	logic                 ex_valid, ex_reg_write, ex_mem_read, ex_mem_write, ex_is_hlt;
	logic                 ex_live, ex_shift;
	logic [3:0]           ex_op;
	logic [REG_SEL_W-1:0] ex_rs, ex_rt;
	logic [DATA_W-1:0]    ex_pc2, ex_data_1, ex_data_2, ex_a, ex_b, alu_b;
	logic [DATA_W-1:0]    alu_result, ex_result, ex_offset, ex_addr;
	logic [2:0]           alu_flags, alu_flag_wen, flag_we, flags_q;
	logic                 bc_taken, taken_q;
	logic [DATA_W-1:0]    bc_target, target_q;

	// Memory and writeback
	logic                 mem_reg_write, mem_read, mem_write, mem_is_hlt, wb_is_hlt;
	logic [REG_SEL_W-1:0] mem_sel;
	logic [DATA_W-1:0]    mem_result, mem_addr, mem_store, dmem_out, mem_wr_data;

	// --------------------------------------------------
	// Fetch
	// --------------------------------------------------
	assign flush = taken_q;
	assign pc_plus_2 = pc + DATA_W'(2);
	// Fetch stops once HLT has been decoded
	assign fetch_off = id_hlt | halting_q;
	// Boot loader port owns the instruction memory during reset
	assign imem_load = rst & imem_wr;
	assign imem_rd_addr = imem_load ? imem_addr : pc[8:1];

	memory1c #(.DEPTH(IMEM_DEPTH)) instr_mem (
		.clk      (clk),
		.rst      (rst),
		.enable   (1'b1),
		.wr       (imem_load),
		.addr     (imem_rd_addr),
		.data_in  (imem_data),
		.data_out (imem_out)
	);

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= '0;
			halting_q <= 1'b0;
		end else if (flush) begin
			pc <= target_q;
			halting_q <= 1'b0;
		end else begin
			if (!stall && !fetch_off)
				pc <= pc_plus_2;
			if (id_hlt)
				halting_q <= 1'b1;
		end
	end

	// IF/ID
	always_ff @(posedge clk) begin
		if (rst || flush) begin
			id_valid <= 1'b0;
			id_instr <= '0;
		end else if (!stall) begin
			id_valid <= !fetch_off;
			id_instr <= fetch_off ? '0 : imem_out;
			id_pc2 <= pc_plus_2;
		end
	end

	// --------------------------------------------------
	// Decode
	// --------------------------------------------------
	assign id_op = id_instr.r.opcode;
	assign id_lhb = (id_op == OP_LHB);
	assign id_llb = (id_op == OP_LLB);
	assign id_load = (id_op == OP_LW);
	assign id_store = (id_op == OP_SW);
	assign id_pcs = (id_op == OP_PCS);
	assign id_hlt = id_valid && (id_op == OP_HLT);

	// Byte loads modify rd, stores read rd as data
	assign id_sel_1 = (id_lhb || id_llb) ? id_instr.r.rd : id_instr.r.rs;
	assign id_sel_2 = id_store ? id_instr.r.rd : id_instr.r.rt;
	assign id_reg_write = id_valid && (!id_op[3] || id_load || id_lhb || id_llb || id_pcs)
		&& (id_instr.r.rd != '0);

	register_file reg_file (
		.clk       (clk),
		.rst       (rst),
		.rd_sel_1  (id_sel_1),
		.rd_sel_2  (id_sel_2),
		.wr_en     (wb_valid),
		.wr_sel    (wb_sel),
		.wr_data   (wb_data),
		.rd_data_1 (id_data_1),
		.rd_data_2 (id_data_2)
	);

	// ID/EX, a stall leaves a bubble behind
	always_ff @(posedge clk) begin
		if (rst || flush || stall) begin
			ex_valid <= 1'b0;
			ex_reg_write <= 1'b0;
			ex_mem_read <= 1'b0;
			ex_mem_write <= 1'b0;
			ex_is_hlt <= 1'b0;
		end else begin
			ex_valid <= id_valid;
			ex_reg_write <= id_reg_write;
			ex_mem_read <= id_valid && id_load;
			ex_mem_write <= id_valid && id_store;
			ex_is_hlt <= id_hlt;
		end
	end

	always_ff @(posedge clk) begin
		ex_instr <= id_instr;
		ex_pc2 <= id_pc2;
		ex_data_1 <= id_data_1;
		ex_data_2 <= id_data_2;
		ex_rs <= id_sel_1;
		ex_rt <= id_sel_2;
	end

	// --------------------------------------------------
	// Execute
	// --------------------------------------------------
	assign ex_op = ex_instr.r.opcode;
	// Instruction right behind a taken branch is dropped here
	assign ex_live = ex_valid && !flush;
	assign ex_shift = (ex_op == OP_SLL) || (ex_op == OP_SRA) || (ex_op == OP_ROR);

	always_comb begin
		case (fwd_a)
			FWD_MEM: ex_a = mem_wr_data;
			FWD_WB:  ex_a = wb_data;
			default: ex_a = ex_data_1;
		endcase
		case (fwd_b)
			FWD_MEM: ex_b = mem_wr_data;
			FWD_WB:  ex_b = wb_data;
			default: ex_b = ex_data_2;
		endcase
	end

	// Shift amount is the rt field itself
	assign alu_b = ex_shift ? {{(DATA_W-4){1'b0}}, ex_instr.r.rt} : ex_b;

	alu alu_unit (
		.in_a     (ex_a),
		.in_b     (alu_b),
		.op       (ex_op[2:0]),
		.result   (alu_result),
		.flags    (alu_flags),
		.flag_wen (alu_flag_wen)
	);

	branch_ctrl branch_unit (
		.instr      (ex_instr),
		.pc_plus_2  (ex_pc2),
		.flags      (flags_q),
		.reg_target (ex_a),
		.taken      (bc_taken),
		.target     (bc_target)
	);

	always_comb begin
		case (ex_op)
			OP_LHB:  ex_result = {ex_instr.i.imm8, ex_a[7:0]};
			OP_LLB:  ex_result = {ex_a[DATA_W-1:8], ex_instr.i.imm8};
			OP_PCS:  ex_result = ex_pc2;
			default: ex_result = alu_result;
		endcase
	end

	// Word address plus signed imm4 in words
	assign ex_offset = {{11{ex_instr.r.rt[3]}}, ex_instr.r.rt, 1'b0};
	assign ex_addr = {ex_a[DATA_W-1:1], 1'b0} + ex_offset;

	assign flag_we = alu_flag_wen & {3{ex_live && !ex_op[3]}};

	always_ff @(posedge clk) begin
		if (rst) begin
			flags_q <= '0;
			taken_q <= 1'b0;
		end else begin
			flags_q <= (alu_flags & flag_we) | (flags_q & ~flag_we);
			taken_q <= bc_taken && ex_live;
		end
	end

	always_ff @(posedge clk)
		target_q <= bc_target;

	// EX/MEM
	always_ff @(posedge clk) begin
		if (rst) begin
			mem_reg_write <= 1'b0;
			mem_read <= 1'b0;
			mem_write <= 1'b0;
			mem_is_hlt <= 1'b0;
		end else begin
			mem_reg_write <= ex_reg_write && !flush;
			mem_read <= ex_mem_read && !flush;
			mem_write <= ex_mem_write && !flush;
			mem_is_hlt <= ex_is_hlt && !flush;
		end
	end

	always_ff @(posedge clk) begin
		mem_sel <= ex_instr.r.rd;
		mem_result <= ex_result;
		mem_addr <= ex_addr;
		mem_store <= ex_b;
	end

	// --------------------------------------------------
	// Memory and writeback
	// --------------------------------------------------
	memory1c #(.DEPTH(DMEM_DEPTH)) data_mem (
		.clk      (clk),
		.rst      (rst),
		.enable   (mem_read | mem_write),
		.wr       (mem_write),
		.addr     (mem_addr[8:1]),
		.data_in  (mem_store),
		.data_out (dmem_out)
	);

	assign mem_wr_data = mem_read ? dmem_out : mem_result;

	// MEM/WB drives the trace directly
	always_ff @(posedge clk) begin
		if (rst) begin
			wb_valid <= 1'b0;
			wb_is_hlt <= 1'b0;
		end else begin
			wb_valid <= mem_reg_write;
			wb_is_hlt <= mem_is_hlt;
		end
	end

	always_ff @(posedge clk) begin
		wb_sel <= mem_sel;
		wb_data <= mem_wr_data;
	end

	hazard_unit hazards (
		.clk           (clk),
		.rst           (rst),
		.id_instr      (id_instr),
		.ex_instr      (ex_instr),
		.ex_mem_read   (ex_mem_read),
		.mem_reg_write (mem_reg_write),
		.mem_sel       (mem_sel),
		.wb_reg_write  (wb_valid),
		.wb_sel        (wb_sel),
		.ex_rs         (ex_rs),
		.ex_rt         (ex_rt),
		.wb_is_hlt     (wb_is_hlt),
		.stall         (stall),
		.fwd_a         (fwd_a),
		.fwd_b         (fwd_b),
		.hlt           (hlt)
	);

	assign pc_out = pc;

	// r0 writes never retire
	assert property (@(posedge clk) disable iff (rst) wb_valid |-> (wb_sel != '0));
	// Branch targets keep the PC word aligned
	assert property (@(posedge clk) disable iff (rst) !pc[0]);

endmodule

// ==== sim/cpu_checker.sv ====
`timescale 1ns/1ps

module cpu_checker
	import cpu_pkg::*;
(
	input logic                 clk,
	input logic                 hlt,
	input logic [DATA_W-1:0]    pc_out,
	input logic                 wb_valid,
	input logic [REG_SEL_W-1:0] wb_sel,
	input logic [DATA_W-1:0]    wb_data
);

	logic [REG_SEL_W-1:0] exp_sel [$];
	logic [DATA_W-1:0]    exp_data [$];
	logic [DATA_W-1:0]    halt_pc;
	bit                   active;
	bit                   halted;
	int                   rec_idx;
	int                   test_errors;
	int                   pass_count;
	int                   fail_count;

	initial begin
		active = 1'b0;
		halted = 1'b0;
		halt_pc = '0;
		rec_idx = 0;
		test_errors = 0;
		pass_count = 0;
		fail_count = 0;
	end

	task automatic begin_test();
		active = 1'b0;
		halted = 1'b0;
		rec_idx = 0;
		test_errors = 0;
		exp_sel.delete();
		exp_data.delete();
	endtask

	task automatic expect_write(input logic [REG_SEL_W-1:0] sel, input logic [DATA_W-1:0] data);
		exp_sel.push_back(sel);
		exp_data.push_back(data);
	endtask

	task automatic arm();
		active = 1'b1;
	endtask

	// Outputs once reset has settled
	task automatic check_reset_state();
		if (hlt !== 1'b0) begin
			$display("ERR hlt: expected 0, got %h", hlt);
			test_errors++;
		end
		if (wb_valid !== 1'b0) begin
			$display("ERR wb_valid: expected 0, got %h", wb_valid);
			test_errors++;
		end
		if (pc_out !== '0) begin
			$display("ERR pc_out: expected 0000, got %h", pc_out);
			test_errors++;
		end
	endtask

	task automatic check_write();
		if (rec_idx >= exp_sel.size()) begin
			$display("unexpected register write to r%0d after the last expected one", wb_sel);
			test_errors++;
		end else begin
			if (wb_sel !== exp_sel[rec_idx]) begin
				$display("ERR wb_sel: expected %h, got %h (record %0d)",
					exp_sel[rec_idx], wb_sel, rec_idx);
				test_errors++;
			end
			if (wb_data !== exp_data[rec_idx]) begin
				$display("ERR wb_data: expected %h, got %h (record %0d)",
					exp_data[rec_idx], wb_data, rec_idx);
				test_errors++;
			end
		end
		rec_idx++;
	endtask

	// --------------------------------------------------
	// Trace and halt monitor
	// --------------------------------------------------
	always @(negedge clk) begin
		if (active) begin
			if (wb_valid !== 1'b0)
				check_write();
			if (halted) begin
				if (hlt !== 1'b1) begin
					$display("hlt dropped low before the next reset");
					test_errors++;
				end
				if (pc_out !== halt_pc) begin
					$display("ERR pc_out: expected %h, got %h", halt_pc, pc_out);
					test_errors++;
				end
			end else if (hlt === 1'b1) begin
				halted = 1'b1;
				halt_pc = pc_out;
			end
		end
	end

	task automatic finish_test(input int num, input logic [DATA_W-1:0] exp_pc,
		input bit timed_out);
		active = 1'b0;
		if (timed_out) begin
			$display("test %0d never raised hlt within the cycle limit", num);
			test_errors++;
		end else if (halt_pc !== exp_pc) begin
			$display("ERR pc_out: expected %h, got %h", exp_pc, halt_pc);
			test_errors++;
		end
		if (rec_idx < exp_sel.size()) begin
			$display("test %0d is missing %0d register writes", num, exp_sel.size() - rec_idx);
			test_errors++;
		end
		if (test_errors == 0) begin
			pass_count++;
			$display("test %0d: ok, %0d writes retired", num, rec_idx);
		end else begin
			fail_count++;
			$display("test %0d: %0d error(s)", num, test_errors);
		end
	endtask

	task automatic report_totals();
		$display("tests passed: %0d, tests failed: %0d", pass_count, fail_count);
	endtask

	function automatic int failures();
		return fail_count;
	endfunction

endmodule

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb
	import cpu_pkg::*;
();

	localparam int STIM_WORDS   = 512;
	localparam int RESET_CYCLES = 5;
	localparam int HALT_TIMEOUT = 2000;
	localparam int HOLD_CYCLES  = 4;

	logic                 clk;
	logic                 rst;
	logic                 imem_wr;
	logic [7:0]           imem_addr;
	logic [DATA_W-1:0]    imem_data;
	logic                 hlt;
	logic [DATA_W-1:0]    pc_out;
	logic                 wb_valid;
	logic [REG_SEL_W-1:0] wb_sel;
	logic [DATA_W-1:0]    wb_data;

	logic [DATA_W-1:0] stim [STIM_WORDS];
	int                stim_ptr;
	int                num_tests;
	int                test_num;

	cpu dut_i (
		.clk       (clk),
		.rst       (rst),
		.imem_wr   (imem_wr),
		.imem_addr (imem_addr),
		.imem_data (imem_data),
		.hlt       (hlt),
		.pc_out    (pc_out),
		.wb_valid  (wb_valid),
		.wb_sel    (wb_sel),
		.wb_data   (wb_data)
	);

	cpu_checker checker_i (
		.clk      (clk),
		.hlt      (hlt),
		.pc_out   (pc_out),
		.wb_valid (wb_valid),
		.wb_sel   (wb_sel),
		.wb_data  (wb_data)
	);

	always #10 clk = ~clk;

	task automatic read_word(output logic [DATA_W-1:0] word);
		word = stim[stim_ptr];
		stim_ptr++;
	endtask

	// Boot loader writes while reset is held
	task automatic load_program();
		logic [DATA_W-1:0] count;
		logic [DATA_W-1:0] word;
		int                i;
		read_word(count);
		for (i = 0; i < count; i++) begin
			read_word(word);
			@(negedge clk);
			imem_wr = 1'b1;
			imem_addr = 8'(i);
			imem_data = word;
		end
		@(negedge clk);
		imem_wr = 1'b0;
	endtask

	task automatic load_expected(output logic [DATA_W-1:0] exp_pc);
		logic [DATA_W-1:0] count;
		logic [DATA_W-1:0] sel_word;
		logic [DATA_W-1:0] data_word;
		int                i;
		read_word(count);
		for (i = 0; i < count; i++) begin
			read_word(sel_word);
			read_word(data_word);
			checker_i.expect_write(sel_word[REG_SEL_W-1:0], data_word);
		end
		read_word(exp_pc);
	endtask

	// --------------------------------------------------
	// One program from load to halt
	// --------------------------------------------------
	task automatic run_test(input int num);
		logic [DATA_W-1:0] exp_pc;
		int                cycles;
		bit                timed_out;
		@(negedge clk);
		rst = 1'b1;
		checker_i.begin_test();
		load_program();
		load_expected(exp_pc);
		repeat (RESET_CYCLES) @(negedge clk);
		checker_i.check_reset_state();
		rst = 1'b0;
		@(posedge clk);
		checker_i.arm();
		cycles = 0;
		while (hlt !== 1'b1 && cycles < HALT_TIMEOUT) begin
			@(negedge clk);
			cycles++;
		end
		timed_out = (hlt !== 1'b1);
		// Halt must hold for a while
		if (!timed_out)
			repeat (HOLD_CYCLES) @(negedge clk);
		@(posedge clk);
		checker_i.finish_test(num, exp_pc, timed_out);
	endtask

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		imem_wr = 1'b0;
		imem_addr = '0;
		imem_data = '0;
		stim_ptr = 0;
		$readmemh("sim/cpu_stim.txt", stim);
		if ($isunknown(stim[0])) begin
			$display("stimulus file sim/cpu_stim.txt could not be read");
			$display("Test failed");
			$finish;
		end else begin
			num_tests = int'(stim[0]);
			stim_ptr = 1;
			for (test_num = 1; test_num <= num_tests; test_num++)
				run_test(test_num);
			checker_i.report_totals();
			if (checker_i.failures() == 0)
				$display("Test completed successfully");
			else
				$display("Test failed");
			$finish;
		end
	end

endmodule

// ==== sim/cpu_stim.txt ====
// Number of tests first, then per test: program word count and words, record count
// and wb_sel wb_data pairs, then the pc_out expected after the halt
0005
// 1: ALU ops, saturation, forwarding from both stages
000e B1FF A17F B201 0312 A480 1542 2653 3761 4874 5983 6A21 7BA2 0C22 F000
000d 1 00FF 1 7FFF 2 0001 3 7FFF 4 8000 5 8000 6 FFFF
     7 7FFF 8 FFF0 9 FFFE A 8000 B 8001 C 0002
001C
// 2: byte loads, store then load, load-use stalls
000a B120 B234 A212 9212 8312 0433 941F 851F B500 F000
0007 1 0020 2 0034 2 1234 3 1234 4 2468 5 2468 5 2400
0014
// 3: every condition code, taken and not taken, two squashed words per taken branch
0024 B105 B205 1312 C202 BEEE BEEE C002 BF01 C802 BEEE BEEE CA02
     BEEE BEEE 1401 C602 BEEE BEEE C402 BF02 0511 C402 BEEE BEEE
     CC02 BF03 A670 0766 CC02 BEEE BEEE 2812 CE02 BEEE BEEE F000
000b 1 0005 2 0005 3 0000 F 0001 4 FFFB F 0002
     5 000A F 0003 6 7000 7 7FFF 8 0000
0048
// 4: register branches and PCS
0011 E100 B20C DE20 BEEE BEEE BEEE E300 B41A 1543 D040 BEEE BEEE BEEE E600 D210 0761
     F000
0007 1 0002 2 000C 3 000E 4 001A 5 000C 6 001C 7 001E
0022
// 5: r0 stays zero, nothing after HLT retires
0008 B055 0100 B233 0022 7302 1430 F000 B577
0004 1 0000 2 0033 3 0033 4 0033
000E

// ==== cpu.f ====
verilog/cpu_pkg.sv
verilog/memory1c.sv
verilog/register_file.sv
verilog/alu.sv
verilog/branch_ctrl.sv
verilog/hazard_unit.sv
verilog/cpu.sv
sim/cpu_checker.sv
sim/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - files:
      - verilog/cpu_pkg.sv
      - verilog/memory1c.sv
      - verilog/register_file.sv
      - verilog/alu.sv
      - verilog/branch_ctrl.sv
      - verilog/hazard_unit.sv
      - verilog/cpu.sv
  - target: simulation
    files:
      - sim/cpu_checker.sv
      - sim/cpu_tb.sv
